/* Makefile */
# Verilator build and run of the L1 arbiter / L2 memory testbench.
# Every variable below can be overridden on the make command line.
VERILATOR ?= verilator
TOP       ?= l1_mem_tb
FILELIST  ?= l1_mem_subsystem.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "test passed" || \
		(echo "test failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hdl/l1_arbiter.sv */
// Fixed-priority arbiter, lowest sub ID wins. Acks are combinational.
// Purely combinational; clk and reset only keep the port list in line with the
// other L2-side blocks.
// Only the data cache may write, and a write pushes both queues together.
`timescale 1ns/1ns
`default_nettype none

module l1_arbiter (
    input  logic clk,
    input  logic reset,

    l1_request_if.arbiter   l1_request  [l1_mem_pkg::L1_CONNECTIONS-1:0],
    l1_return_if.arbiter    l1_response [l1_mem_pkg::L1_CONNECTIONS-1:0],

    l2_requester_if.requester l2
);
    import l1_mem_pkg::*;

    logic [L1_CONNECTIONS-1:0] requests;
    logic [L1_CONNECTIONS-1:0] acks;
    logic [L1_CONNECTIONS-1:0] req_rnw;

    word_addr_t req_addr [L1_CONNECTIONS];
    be_t        req_be   [L1_CONNECTIONS];
    burst_t     req_size [L1_CONNECTIONS];

    logic push_ready;
    logic request_exists;

    // flatten the interface array so it can be indexed in loops
    for (genvar i = 0; i < L1_CONNECTIONS; i++) begin : g_req
        assign requests[i] = l1_request[i].request;
        assign req_addr[i] = l1_request[i].addr[31:2];   // drop byte offset
        assign req_rnw[i]  = l1_request[i].rnw;
        assign req_be[i]   = l1_request[i].be;
        assign req_size[i] = l1_request[i].size;
        assign l1_request[i].ack = acks[i];
    end

    // the queues drain at different rates, both need room
    assign push_ready = ~l2.request_full & ~l2.data_full;
    assign request_exists = |requests;

    assign l2.request_push = push_ready & request_exists;

    // priority grant, 0 first
    always_comb begin
        logic busy;
        busy = 1'b0;
        for (int j = 0; j < L1_CONNECTIONS; j++) begin
            acks[j] = requests[j] & push_ready & ~busy;
            busy |= requests[j];
        end
    end

    // dcache has top priority, so any dcache write request is also the winner
    assign l2.wr_data_push = push_ready & l1_request[L1_DCACHE_ID].request
                           & ~l1_request[L1_DCACHE_ID].rnw;
    assign l2.wr_data = l1_request[L1_DCACHE_ID].data;

    // request mux, default to the lowest priority requester
    always_comb begin
        l2.addr   = req_addr[L1_CONNECTIONS-1];
        l2.rnw    = req_rnw[L1_CONNECTIONS-1];
        l2.be     = req_be[L1_CONNECTIONS-1];
        l2.size   = req_size[L1_CONNECTIONS-1];
        l2.sub_id = sub_id_t'(L1_CONNECTIONS-1);
        for (int j = L1_CONNECTIONS-2; j >= 0; j--) begin
            if (requests[j]) begin
                l2.addr   = req_addr[j];
                l2.rnw    = req_rnw[j];
                l2.be     = req_be[j];
                l2.size   = req_size[j];
                l2.sub_id = sub_id_t'(j);
            end
        end
    end

    // read data goes everywhere, valid only to the owner
    for (genvar i = 0; i < L1_CONNECTIONS; i++) begin : g_resp
        assign l1_response[i].data = l2.rd_data;
        assign l1_response[i].data_valid = l2.rd_data_valid
                                         && (l2.rd_sub_id == sub_id_t'(i));
    end

endmodule

`default_nettype wire

/* hdl/l1_mem_ifs.sv */
// Interfaces between the L1 requesters, the arbiter and the L2 side.
// request is a level held until ack; data_valid pulses once per returned word.
// Read data has no back-pressure.
`timescale 1ns/1ns
`default_nettype none

interface l1_request_if;
    import l1_mem_pkg::*;

    logic   request;
    addr_t  addr;
    logic   rnw;     // 1 = read
    be_t    be;
    burst_t size;
    data_t  data;    // write data
    logic   ack;     // transfer happens in the cycle ack is high

    modport requester (output request, addr, rnw, be, size, data, input ack);
    modport arbiter (input request, addr, rnw, be, size, data, output ack);
endinterface

interface l1_return_if;
    import l1_mem_pkg::*;

    data_t data;
    logic  data_valid;

    modport arbiter (output data, data_valid);
    modport requester (input data, data_valid);
endinterface

interface l2_requester_if;
    import l1_mem_pkg::*;

    // request path, arbiter to L2
    logic       request_push;
    word_addr_t addr;
    logic       rnw;
    be_t        be;
    burst_t     size;
    sub_id_t    sub_id;
    logic       wr_data_push;
    data_t      wr_data;

    // status and read return, L2 to arbiter
    logic       request_full;
    logic       data_full;
    data_t      rd_data;
    logic       rd_data_valid;
    sub_id_t    rd_sub_id;

    modport requester (
        output request_push, addr, rnw, be, size, sub_id, wr_data_push, wr_data,
        input  request_full, data_full, rd_data, rd_data_valid, rd_sub_id
    );

    modport l2 (
        input  request_push, addr, rnw, be, size, sub_id, wr_data_push, wr_data,
        output request_full, data_full, rd_data, rd_data_valid, rd_sub_id
    );
endinterface

`default_nettype wire

/* hdl/l1_mem_pkg.sv */
// Shared widths, requester IDs and sizes for the L1 arbiter and the L2 model.
// Sub ID 0 (data cache) has the highest priority.
// The memory model only decodes the low index bits of the word address.
`default_nettype none

package l1_mem_pkg;

    localparam int L1_CONNECTIONS = 2;
    localparam int L1_DCACHE_ID   = 0;   // reads and single-word writes
    localparam int L1_ICACHE_ID   = 1;   // burst reads only

    localparam int L2_QUEUE_DEPTH = 4;   // entries per L2 queue
    localparam int MEM_WORDS      = 256;

    // byte address and the word address it maps to
    typedef logic [31:0] addr_t;
    typedef logic [29:0] word_addr_t;

    typedef logic [31:0] data_t;
    typedef logic [3:0]  be_t;

    // number of words minus one
    typedef logic [1:0]  burst_t;

    typedef logic [0:0]  sub_id_t;

    typedef logic [$clog2(MEM_WORDS)-1:0] mem_index_t;

    // L2 memory controller states
    typedef enum logic [1:0] {
        L2_IDLE,
        L2_READ,
        L2_WRITE
    } l2_state_t;

endpackage

`default_nettype wire

/* hdl/l1_mem_top.sv */
// Memory side top level: data cache port (dc_) and instruction cache port (ic_).
// The ic port is read-only; its rnw and byte enables are tied inside.
// Hold each request and its fields until the matching ack is high.
`timescale 1ns/1ns
`default_nettype none

module l1_mem_top (
    input  logic               clk,
    input  logic               reset,

    input  logic               dc_request,
    input  logic               dc_rnw,
    input  l1_mem_pkg::addr_t  dc_addr,
    input  l1_mem_pkg::be_t    dc_be,
    input  l1_mem_pkg::burst_t dc_size,
    input  l1_mem_pkg::data_t  dc_wr_data,
    output logic               dc_ack,
    output l1_mem_pkg::data_t  dc_rd_data,
    output logic               dc_rd_valid,

    input  logic               ic_request,
    input  l1_mem_pkg::addr_t  ic_addr,
    input  l1_mem_pkg::burst_t ic_size,
    output logic               ic_ack,
    output l1_mem_pkg::data_t  ic_rd_data,
    output logic               ic_rd_valid
);
    import l1_mem_pkg::*;

    l1_request_if   l1_request  [L1_CONNECTIONS-1:0] ();
    l1_return_if    l1_response [L1_CONNECTIONS-1:0] ();
    l2_requester_if l2 ();

    // data cache side
    assign l1_request[L1_DCACHE_ID].request = dc_request;
    assign l1_request[L1_DCACHE_ID].addr    = dc_addr;
    assign l1_request[L1_DCACHE_ID].rnw     = dc_rnw;
    assign l1_request[L1_DCACHE_ID].be      = dc_be;
    assign l1_request[L1_DCACHE_ID].size    = dc_size;
    assign l1_request[L1_DCACHE_ID].data    = dc_wr_data;
    assign dc_ack      = l1_request[L1_DCACHE_ID].ack;
    assign dc_rd_data  = l1_response[L1_DCACHE_ID].data;
    assign dc_rd_valid = l1_response[L1_DCACHE_ID].data_valid;

    // instruction cache side, reads only
    assign l1_request[L1_ICACHE_ID].request = ic_request;
    assign l1_request[L1_ICACHE_ID].addr    = ic_addr;
    assign l1_request[L1_ICACHE_ID].rnw     = 1'b1;
    assign l1_request[L1_ICACHE_ID].be      = '1;
    assign l1_request[L1_ICACHE_ID].size    = ic_size;
    assign l1_request[L1_ICACHE_ID].data    = '0;
    assign ic_ack      = l1_request[L1_ICACHE_ID].ack;
    assign ic_rd_data  = l1_response[L1_ICACHE_ID].data;
    assign ic_rd_valid = l1_response[L1_ICACHE_ID].data_valid;

    l1_arbiter arbiter (
        .clk         (clk),
        .reset       (reset),
        .l1_request  (l1_request),
        .l1_response (l1_response),
        .l2          (l2)
    );

    l2_memory memory (
        .clk   (clk),
        .reset (reset),
        .l2    (l2)
    );

endmodule

`default_nettype wire

/* hdl/l2_memory.sv */
// Word-addressed L2 memory model behind an address queue and a write-data queue.
// Only the low index bits of the word address are decoded; bursts wrap at MEM_WORDS.
// Read words leave one per cycle starting the cycle after the address pop.
// Memory contents are not initialised.
`timescale 1ns/1ns
`default_nettype none

module l2_memory (
    input  logic clk,
    input  logic reset,

    l2_requester_if.l2 l2
);
    import l1_mem_pkg::*;

    // address queue entry {addr, rnw, be, size, sub_id}
    logic [$bits(word_addr_t)+$bits(be_t)+$bits(burst_t)+$bits(sub_id_t):0] req_push_data;
    logic [$bits(word_addr_t)+$bits(be_t)+$bits(burst_t)+$bits(sub_id_t):0] req_pop_data;

    word_addr_t pop_addr;
    logic       pop_rnw;
    be_t        pop_be;
    burst_t     pop_size;
    sub_id_t    pop_sub_id;

    logic  req_pop;
    logic  req_empty;
    logic  data_pop;
    logic  data_empty;
    data_t data_pop_data;

    l2_state_t state;
    burst_t    word_count;

    // latched request
    mem_index_t cur_index;
    be_t        cur_be;
    burst_t     cur_size;
    sub_id_t    cur_sub_id;

    data_t mem [MEM_WORDS];

    assign req_push_data = {l2.addr, l2.rnw, l2.be, l2.size, l2.sub_id};
    assign {pop_addr, pop_rnw, pop_be, pop_size, pop_sub_id} = req_pop_data;

    l2_request_queue #(.WIDTH($bits(req_push_data)), .DEPTH(L2_QUEUE_DEPTH)) request_queue (
        .clk       (clk),
        .reset     (reset),
        .push      (l2.request_push),
        .pop       (req_pop),
        .push_data (req_push_data),
        .pop_data  (req_pop_data),
        .full      (l2.request_full),
        .empty     (req_empty)
    );

    l2_request_queue #(.WIDTH($bits(data_t)), .DEPTH(L2_QUEUE_DEPTH)) data_queue (
        .clk       (clk),
        .reset     (reset),
        .push      (l2.wr_data_push),
        .pop       (data_pop),
        .push_data (l2.wr_data),
        .pop_data  (data_pop_data),
        .full      (l2.data_full),
        .empty     (data_empty)
    );

    assign req_pop  = (state == L2_IDLE) && !req_empty;
    assign data_pop = (state == L2_WRITE) && !data_empty;

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= L2_IDLE;
            word_count <= '0;
        end else begin
            case (state)
                L2_IDLE: if (req_pop) begin
                    state      <= pop_rnw ? L2_READ : L2_WRITE;
                    word_count <= '0;
                end
                L2_READ: begin
                    if (word_count == cur_size)
                        state <= L2_IDLE;      // last word of the burst
                    else
                        word_count <= word_count + 1'b1;
                end
                L2_WRITE: if (data_pop)
                    state <= L2_IDLE;
                default: state <= L2_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_pop) begin
            cur_index  <= mem_index_t'(pop_addr);
            cur_be     <= pop_be;
            cur_size   <= pop_size;
            cur_sub_id <= pop_sub_id;
        end else if (state == L2_READ) begin
            cur_index <= cur_index + 1'b1;   // wraps with the index width
        end
    end

    // byte-masked write merge
    always_ff @(posedge clk) begin
        if (data_pop) begin
            for (int b = 0; b < $bits(be_t); b++) begin
                if (cur_be[b])
                    mem[cur_index][8*b +: 8] <= data_pop_data[8*b +: 8];
            end
        end
    end

    assign l2.rd_data       = mem[cur_index];
    assign l2.rd_data_valid = (state == L2_READ);
    assign l2.rd_sub_id     = cur_sub_id;

endmodule

`default_nettype wire

/* hdl/l2_request_queue.sv */
// Synchronous FIFO with full and empty flags.
// Push while full and pop while empty are ignored.
// pop_data always shows the oldest entry and is only meaningful when not empty.
`timescale 1ns/1ns
`default_nettype none

module l2_request_queue #(
    parameter int WIDTH = 32,
    parameter int DEPTH = 4
) (
    input  logic             clk,
    input  logic             reset,

    input  logic             push,
    input  logic             pop,
    input  logic [WIDTH-1:0] push_data,
    output logic [WIDTH-1:0] pop_data,

    output logic             full,
    output logic             empty
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0] entries [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic do_push;
    logic do_pop;

    // wraps at DEPTH, so non power of two depths work
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full  = (count == CNT_W'(DEPTH));
    assign empty = (count == '0);

    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)
                rd_ptr <= next_ptr(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // both or neither
            endcase
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (do_push)
            entries[wr_ptr] <= push_data;
    end

    assign pop_data = entries[rd_ptr];

endmodule

`default_nettype wire

/* l1_mem_subsystem.f */
+incdir+verification
hdl/l1_mem_pkg.sv
hdl/l1_mem_ifs.sv
hdl/l2_request_queue.sv
hdl/l1_arbiter.sv
hdl/l2_memory.sv
hdl/l1_mem_top.sv
verification/l1_mem_tb.sv

/* verification/l1_mem_tb_tasks.svh */
// Request and collect helpers plus the directed tests of l1_mem_tb.
// Included inside the testbench module and uses its signals and counters.
`ifndef L1_MEM_TB_TASKS_SVH
`define L1_MEM_TB_TASKS_SVH

// byte-enabled merge into the reference memory
task automatic ref_write(input addr_t addr, input be_t be, input data_t data);
    mem_index_t idx;
    idx = mem_index_t'(addr[31:2]);
    for (int b = 0; b < 4; b++) begin
        if (be[b])
            ref_mem[idx][8*b +: 8] = data[8*b +: 8];
    end
endtask

task automatic expect_read(input int port, input addr_t addr, input burst_t size);
    mem_index_t idx;
    idx = mem_index_t'(addr[31:2]);
    for (int w = 0; w <= int'(size); w++) begin
        exp_data.push_back(ref_mem[idx]);
        exp_port.push_back(port);
        idx++;   // wraps at MEM_WORDS
    end
    words_expected += int'(size) + 1;
endtask

// present one request on a port and hold it until acked
task automatic transfer(input int port, input logic rnw, input addr_t addr, input be_t be,
                        input burst_t size, input data_t data);
    int   cycles;
    logic acked;
    @(negedge clk);
    if (port == L1_DCACHE_ID) begin
        dc_request = 1'b1;
        dc_rnw     = rnw;
        dc_addr    = addr;
        dc_be      = be;
        dc_size    = size;
        dc_wr_data = data;
    end else begin
        ic_request = 1'b1;
        ic_addr    = addr;
        ic_size    = size;
    end
    cycles = 0;
    acked  = 1'b0;
    while (!acked && cycles < ACK_TIMEOUT) begin
        @(posedge clk);
        cycles++;
        acked = (port == L1_DCACHE_ID) ? dc_ack : ic_ack;
    end
    if (!acked) begin
        timeouts++;
        $display("timeout: port %0d request to %h was never acked", port, addr);
    end else if (rnw) begin
        expect_read(port, addr, size);
    end else begin
        ref_write(addr, be, data);
    end
    last_ack_time[port] = $time;
endtask

task automatic release_port(input int port);
    @(negedge clk);
    if (port == L1_DCACHE_ID)
        dc_request = 1'b0;
    else
        ic_request = 1'b0;
endtask

task automatic collect_word(input int port, input data_t data);
    string name;
    name = (port == L1_DCACHE_ID) ? "dc_rd_data" : "ic_rd_data";
    words_seen++;
    if (exp_data.size() == 0) begin
        routing_errors++;
        $display("port %0d returned a word nobody asked for at %0t", port, $time);
    end else if (exp_port[0] != port) begin
        routing_errors++;
        $display("word for port %0d arrived on port %0d at %0t", exp_port[0], port, $time);
        void'(exp_data.pop_front());
        void'(exp_port.pop_front());
    end else begin
        void'(exp_port.pop_front());
        check_value(name, data, exp_data.pop_front());
    end
endtask

task automatic wait_drain();
    int cycles;
    cycles = 0;
    while (exp_data.size() > 0 && cycles < DRAIN_TIMEOUT) begin
        @(posedge clk);
        cycles++;
    end
    if (exp_data.size() > 0) begin
        timeouts++;
        $display("timeout: %0d read words never came back", exp_data.size());
    end
endtask

task automatic test_reset_state();
    for (int i = 0; i < 8; i++) begin
        @(posedge clk);
        check_value("dc_ack", dc_ack, 0);
        check_value("ic_ack", ic_ack, 0);
        check_value("dc_rd_valid", dc_rd_valid, 0);
        check_value("ic_rd_valid", ic_rd_valid, 0);
    end
endtask

// pattern mixes every address bit so aliasing shows up
task automatic fill_memory();
    for (int i = 0; i < MEM_WORDS; i++)
        transfer(L1_DCACHE_ID, 1'b0, addr_t'(i) << 2, 4'hf, 2'd0,
                 (32'(i) * 32'h9e3779b1) ^ {24'ha5c3e1, 8'(i)});
    release_port(L1_DCACHE_ID);
endtask

task automatic test_write_read();
    logic [31:0] rnd;
    rnd = SEED;
    for (int i = 0; i < 8; i++) begin
        rnd = lcg(rnd);
        transfer(L1_DCACHE_ID, 1'b0, addr_t'(16 + i) << 2, 4'hf, 2'd0, rnd);
    end
    for (int i = 0; i < 8; i++) begin   // partial writes over the same words
        rnd = lcg(rnd);
        transfer(L1_DCACHE_ID, 1'b0, addr_t'(16 + i) << 2, rnd[23:20], 2'd0, ~rnd);
    end
    for (int i = 0; i < 8; i++)
        transfer(L1_DCACHE_ID, 1'b1, addr_t'(16 + i) << 2, 4'hf, 2'd0, '0);
    release_port(L1_DCACHE_ID);
    wait_drain();
endtask

task automatic test_ic_bursts();
    for (int j = 0; j < 4; j++) begin
        transfer(L1_DCACHE_ID, 1'b0, addr_t'(100 + j) << 2, 4'hf, 2'd0, 32'h1000_0000 + j);
        transfer(L1_DCACHE_ID, 1'b0, addr_t'((254 + j) % MEM_WORDS) << 2, 4'hf, 2'd0,
                 32'h2000_0000 + j);
    end
    release_port(L1_DCACHE_ID);
    for (int s = 0; s < 4; s++)
        transfer(L1_ICACHE_ID, 1'b1, addr_t'(100) << 2, 4'hf, burst_t'(s), '0);
    transfer(L1_ICACHE_ID, 1'b1, addr_t'(254) << 2, 4'hf, 2'd3, '0);   // wraps to word 1
    release_port(L1_ICACHE_ID);
    wait_drain();
endtask

task automatic test_priority();
    fork
        begin
            transfer(L1_DCACHE_ID, 1'b1, addr_t'(20) << 2, 4'hf, 2'd0, '0);
            release_port(L1_DCACHE_ID);
        end
        transfer(L1_ICACHE_ID, 1'b1, addr_t'(40) << 2, 4'hf, 2'd2, '0);
    join
    release_port(L1_ICACHE_ID);
    if (last_ack_time[L1_ICACHE_ID] <= last_ack_time[L1_DCACHE_ID]) begin
        protocol_errors++;
        $display("ic was acked before or together with dc");
    end
    wait_drain();
endtask

task automatic test_stress();
    int stalls_before;
    stalls_before = stall_cycles;
    fork
        begin
            logic [31:0] dc_rnd;
            dc_rnd = SEED ^ 32'h1;
            for (int i = 0; i < STRESS_OPS; i++) begin
                dc_rnd = lcg(dc_rnd);
                transfer(L1_DCACHE_ID, dc_rnd[31], addr_t'(dc_rnd[30:23]) << 2,
                         dc_rnd[22:19], 2'd0, lcg(dc_rnd));
            end
            release_port(L1_DCACHE_ID);
        end
        begin
            logic [31:0] ic_rnd;
            ic_rnd = SEED ^ 32'h2;
            for (int i = 0; i < STRESS_OPS; i++) begin
                ic_rnd = lcg(ic_rnd);
                transfer(L1_ICACHE_ID, 1'b1, addr_t'(ic_rnd[30:23]) << 2, 4'hf,
                         ic_rnd[22] ? 2'd3 : ic_rnd[21:20], '0);   // mostly long bursts
            end
            release_port(L1_ICACHE_ID);
        end
    join
    wait_drain();
    if (stall_cycles == stalls_before) begin
        protocol_errors++;
        $display("stress run never saw back-pressure from full queues");
    end
endtask

`endif

/* verification/l1_mem_tb.sv */
// Testbench for l1_mem_top; the directed tests sit in l1_mem_tb_tasks.svh.
// The whole L2 memory is written through the dc port before any read is checked.
// Every wait is bounded; a timeout counts as an error and the run still ends.
`timescale 1ns/1ns
`default_nettype none

module l1_mem_tb;
    import l1_mem_pkg::*;

    localparam logic [31:0] SEED = 32'he57f;
    localparam int ACK_TIMEOUT   = 200;    // cycles
    localparam int DRAIN_TIMEOUT = 4000;
    localparam int STRESS_OPS    = 60;     // per port

    logic   clk;
    logic   reset;
    logic   dc_request;
    logic   dc_rnw;
    addr_t  dc_addr;
    be_t    dc_be;
    burst_t dc_size;
    data_t  dc_wr_data;
    logic   dc_ack;
    data_t  dc_rd_data;
    logic   dc_rd_valid;
    logic   ic_request;
    addr_t  ic_addr;
    burst_t ic_size;
    logic   ic_ack;
    data_t  ic_rd_data;
    logic   ic_rd_valid;

    data_t ref_mem [MEM_WORDS];    // reference copy of the L2 contents
    data_t exp_data [$];           // expected read words in acceptance order
    int    exp_port [$];           // owner of each expected word
    time   last_ack_time [L1_CONNECTIONS];

    int value_errors    = 0;
    int routing_errors  = 0;
    int protocol_errors = 0;
    int timeouts        = 0;
    int words_expected  = 0;
    int words_seen      = 0;
    int stall_cycles    = 0;

    l1_mem_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] lcg(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            value_errors++;
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, expected);
        end
    endtask

    `include "l1_mem_tb_tasks.svh"

    // collectors and protocol monitor sample at the rising edge
    always @(posedge clk) begin
        if (!reset) begin
            if (dc_rd_valid)
                collect_word(L1_DCACHE_ID, dc_rd_data);
            if (ic_rd_valid)
                collect_word(L1_ICACHE_ID, ic_rd_data);
            if (ic_ack && dc_request) begin
                protocol_errors++;
                $display("ic acked at %0t while dc was requesting", $time);
            end
            if ((dc_ack && !dc_request) || (ic_ack && !ic_request)) begin
                protocol_errors++;
                $display("ack without a request at %0t", $time);
            end
            if ((dc_request || ic_request) && !dc_ack && !ic_ack)
                stall_cycles++;   // back-pressure
        end
    end

    initial begin
        reset      = 1'b1;
        dc_request = 1'b0;
        dc_rnw     = 1'b1;
        dc_addr    = '0;
        dc_be      = '0;
        dc_size    = '0;
        dc_wr_data = '0;
        ic_request = 1'b0;
        ic_addr    = '0;
        ic_size    = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        test_reset_state();
        fill_memory();
        test_write_read();
        test_ic_bursts();
        test_priority();
        test_stress();
        repeat (4) @(posedge clk);   // longest burst, a surplus word shows up here
        check_value("words returned", words_seen, words_expected);

        $display("errors: value %0d routing %0d protocol %0d timeout %0d",
                 value_errors, routing_errors, protocol_errors, timeouts);
        if (value_errors + routing_errors + protocol_errors + timeouts == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
